/* all.f */
+incdir+design
design/softreg_pkg.sv
design/rst_pipe.sv
design/sr_pipe.sv
design/axil_softreg_bridge.sv
design/softreg_router.sv
design/app_reg_bank.sv
design/shell_top.sv
tb/shell_assertions.sv
tb/shell_tb.sv

/* design/app_reg_bank.sv */
// Application register bank
`default_nettype none

`include "softreg_consts.svh"

module app_reg_bank import softreg_pkg::*; #(
	parameter int APP_ID = 0
) (
	input  logic     global_clk,
	input  logic     rst_n,
	input  logic     req_valid,
	input  sr_cmd_t  req_cmd,
	output logic     resp_valid,
	output sr_data_t resp_data
);

	localparam int REG_SEL_W = 2;
	localparam int NUM_REGS  = 1 << REG_SEL_W;

	logic [REG_SEL_W-1:0] reg_idx;
	sr_data_t             scratch [1:NUM_REGS-1];

	assign reg_idx = req_cmd.addr[`REG_SEL_LSB +: REG_SEL_W];

	// Register 0 is the read-only identity
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
			for (int i = 1; i < NUM_REGS; i++) begin
				scratch[i] <= '0;
			end
		end else begin
			resp_valid <= req_valid && !req_cmd.write;
			if (req_valid && req_cmd.write && (reg_idx != '0)) begin
				scratch[reg_idx] <= req_cmd.data;
			end
		end
	end

	// Read data for the response pulse
	always_ff @(posedge global_clk) begin
		if (req_valid && !req_cmd.write) begin
			resp_data <= (reg_idx == '0) ? sr_data_t'(APP_ID) : scratch[reg_idx];
		end
	end

endmodule

`default_nettype wire

/* design/axil_softreg_bridge.sv */
// AXI-Lite to SoftReg bridge
`default_nettype none

`include "softreg_consts.svh"

module axil_softreg_bridge import softreg_pkg::*; (
	input  logic                     global_clk,
	input  logic                     rst_n,

	// Write address and data
	input  logic                     awvalid,
	input  sr_addr_t                 awaddr,
	output logic                     awready,
	input  logic                     wvalid,
	input  logic [`AXIL_DATA_W-1:0]  wdata,
	input  logic [`AXIL_DATA_W/8-1:0] wstrb,
	output logic                     wready,

	// Write response
	output logic                     bvalid,
	output logic [1:0]               bresp,
	input  logic                     bready,

	// Read address and data
	input  logic                     arvalid,
	input  sr_addr_t                 araddr,
	output logic                     arready,
	output logic                     rvalid,
	output logic [`AXIL_DATA_W-1:0]  rdata,
	output logic [1:0]               rresp,
	input  logic                     rready,

	// SoftReg master side
	output logic                     req_valid,
	output logic                     req_write,
	output sr_addr_t                 req_addr,
	output sr_data_t                 req_data,
	input  logic                     resp_valid,
	input  sr_data_t                 resp_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RD_WAIT,
		ST_RESP
	} state_t;

	state_t state;
	logic   live_q;
	logic   can_accept;
	logic   wr_go;
	logic   rd_go;

	// --------------------
	// Host handshakes
	// --------------------
	// Nothing accepted until the first cycle after reset release
	assign can_accept = live_q && (state == ST_IDLE);

	// Write takes priority when both channels arrive together
	assign wr_go   = can_accept && awvalid && wvalid;
	assign awready = wr_go;
	assign wready  = wr_go;
	assign arready = can_accept && !(awvalid && wvalid);
	assign rd_go   = arready && arvalid;

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// --------------------
	// Control FSM
	// --------------------
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			live_q    <= 1'b0;
			state     <= ST_IDLE;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			live_q    <= 1'b1;
			req_valid <= wr_go || rd_go;
			case (state)
				ST_IDLE: begin
					if (wr_go) begin
						bvalid <= 1'b1;
						state  <= ST_RESP;
					end else if (rd_go) begin
						state <= ST_RD_WAIT;
					end
				end
				ST_RD_WAIT: begin
					if (resp_valid) begin
						rvalid <= 1'b1;
						state  <= ST_RESP;
					end
				end
				ST_RESP: begin
					// Hold until the host takes the response
					if (bvalid && bready) begin
						bvalid <= 1'b0;
						state  <= ST_IDLE;
					end
					if (rvalid && rready) begin
						rvalid <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request and read data registers
	always_ff @(posedge global_clk) begin
		if (wr_go || rd_go) begin
			req_write <= wr_go;
			req_addr  <= wr_go ? awaddr : araddr;
			// Strobes are ignored so every write is a full word
			req_data  <= {{(`SR_DATA_W-`AXIL_DATA_W){1'b0}}, wdata};
		end
		if ((state == ST_RD_WAIT) && resp_valid) begin
			rdata <= resp_data[`AXIL_DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* design/rst_pipe.sv */
// Reset synchronizer
`default_nettype none

module rst_pipe (
	input  logic global_clk,
	input  logic rst_n,
	output logic rst_sync_n
);

	localparam int SYNC_STAGES = 3;

	logic [SYNC_STAGES-1:0] sync_q;

	// Assert at once, release after the chain fills with ones
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign rst_sync_n = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

/* design/shell_top.sv */
// Host register shell top
`default_nettype none

`include "softreg_consts.svh"

module shell_top import softreg_pkg::*; (
	input  logic                      global_clk,
	input  logic                      rst_n,
	input  logic                      awvalid,
	input  sr_addr_t                  awaddr,
	output logic                      awready,
	input  logic                      wvalid,
	input  logic [`AXIL_DATA_W-1:0]   wdata,
	input  logic [`AXIL_DATA_W/8-1:0] wstrb,
	output logic                      wready,
	output logic                      bvalid,
	output logic [1:0]                bresp,
	input  logic                      bready,
	input  logic                      arvalid,
	input  sr_addr_t                  araddr,
	output logic                      arready,
	output logic                      rvalid,
	output logic [`AXIL_DATA_W-1:0]   rdata,
	output logic [1:0]                rresp,
	input  logic                      rready
);

	logic                 rst_sync_n;
	logic                 req_valid;
	logic                 req_write;
	sr_addr_t             req_addr;
	sr_data_t             req_data;
	logic                 resp_valid;
	sr_data_t             resp_data;
	logic [`NUM_APPS-1:0] app_req_valid;
	sr_cmd_t              app_req_cmd [`NUM_APPS];
	logic [`NUM_APPS-1:0] app_resp_valid;
	sr_data_t             app_resp_data [`NUM_APPS];

	rst_pipe u_rst_pipe (.global_clk(global_clk), .rst_n(rst_n), .rst_sync_n(rst_sync_n));

	axil_softreg_bridge u_bridge (
		.global_clk(global_clk), .rst_n(rst_sync_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_data(req_data), .resp_valid(resp_valid), .resp_data(resp_data)
	);

	softreg_router u_router (
		.global_clk(global_clk), .rst_n(rst_sync_n),
		.req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
		.req_data(req_data), .resp_valid(resp_valid), .resp_data(resp_data),
		.app_req_valid(app_req_valid), .app_req_cmd(app_req_cmd),
		.app_resp_valid(app_resp_valid), .app_resp_data(app_resp_data)
	);

	// --------------------
	// Per-application lanes
	// --------------------
	for (genvar k = 0; k < `NUM_APPS; k++) begin : g_app
		logic     bank_req_valid;
		sr_cmd_t  bank_req_cmd;
		logic     bank_resp_valid;
		sr_data_t bank_resp_data;

		sr_pipe #(.payload_t(sr_cmd_t), .STAGES(`REQ_PIPE_STAGES)) u_req_pipe (
			.global_clk(global_clk), .rst_n(rst_sync_n),
			.in_valid(app_req_valid[k]), .in_payload(app_req_cmd[k]),
			.out_valid(bank_req_valid), .out_payload(bank_req_cmd)
		);

		app_reg_bank #(.APP_ID(k)) u_bank (
			.global_clk(global_clk), .rst_n(rst_sync_n),
			.req_valid(bank_req_valid), .req_cmd(bank_req_cmd),
			.resp_valid(bank_resp_valid), .resp_data(bank_resp_data)
		);

		sr_pipe #(.payload_t(sr_data_t), .STAGES(`RESP_PIPE_STAGES)) u_resp_pipe (
			.global_clk(global_clk), .rst_n(rst_sync_n),
			.in_valid(bank_resp_valid), .in_payload(bank_resp_data),
			.out_valid(app_resp_valid[k]), .out_payload(app_resp_data[k])
		);
	end

endmodule

`default_nettype wire

/* design/softreg_consts.svh */
// SoftReg shell constants
`ifndef SOFTREG_CONSTS_SVH
`define SOFTREG_CONSTS_SVH

// Bus widths
`define SR_ADDR_W 32
`define SR_DATA_W 64
`define AXIL_DATA_W 32

// Number of application slots behind the router
`define NUM_APPS 4

// Address fields of two bits each
`define APP_SEL_LSB 4
`define REG_SEL_LSB 2

// Buffering on every application lane
`define REQ_PIPE_STAGES 2
`define RESP_PIPE_STAGES 2

`endif

/* design/softreg_pkg.sv */
// SoftReg shared types
`default_nettype none

`include "softreg_consts.svh"

package softreg_pkg;

	// Host byte address
	typedef logic [`SR_ADDR_W-1:0] sr_addr_t;

	// SoftReg data word
	typedef logic [`SR_DATA_W-1:0] sr_data_t;

	// Application slot number
	typedef logic [$clog2(`NUM_APPS)-1:0] app_idx_t;

	// --------------------
	// Request payload carried on the lanes
	// --------------------
	typedef struct packed {
		logic     write;
		sr_addr_t addr;
		sr_data_t data;
	} sr_cmd_t;

endpackage

`default_nettype wire

/* design/softreg_router.sv */
// SoftReg application router
`default_nettype none

`include "softreg_consts.svh"

module softreg_router import softreg_pkg::*; (
	input  logic                 global_clk,
	input  logic                 rst_n,

	// From the bridge
	input  logic                 req_valid,
	input  logic                 req_write,
	input  sr_addr_t             req_addr,
	input  sr_data_t             req_data,
	output logic                 resp_valid,
	output sr_data_t             resp_data,

	// Application lanes
	output logic [`NUM_APPS-1:0] app_req_valid,
	output sr_cmd_t              app_req_cmd [`NUM_APPS],
	input  logic [`NUM_APPS-1:0] app_resp_valid,
	input  sr_data_t             app_resp_data [`NUM_APPS]
);

	app_idx_t             sel;
	logic [`NUM_APPS-1:0] sel_onehot;
	sr_cmd_t              req_cmd;
	sr_data_t             resp_or;

	// --------------------
	// Request fan-out
	// --------------------
	// Bits above the application field alias
	assign sel = req_addr[`APP_SEL_LSB +: $bits(app_idx_t)];

	assign req_cmd = '{write: req_write, addr: req_addr, data: req_data};

	always_comb begin
		sel_onehot      = '0;
		sel_onehot[sel] = req_valid;
	end

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			app_req_valid <= '0;
		end else begin
			app_req_valid <= sel_onehot;
		end
	end

	// Only the chosen lane loads the command
	always_ff @(posedge global_clk) begin
		for (int i = 0; i < `NUM_APPS; i++) begin
			if (sel_onehot[i]) begin
				app_req_cmd[i] <= req_cmd;
			end
		end
	end

	// --------------------
	// Response merge
	// --------------------
	// At most one lane answers at a time
	always_comb begin
		resp_or = '0;
		for (int i = 0; i < `NUM_APPS; i++) begin
			if (app_resp_valid[i]) begin
				resp_or = resp_or | app_resp_data[i];
			end
		end
	end

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= |app_resp_valid;
		end
	end

	always_ff @(posedge global_clk) begin
		resp_data <= resp_or;
	end

endmodule

`default_nettype wire

/* design/sr_pipe.sv */
// SoftReg lane pipeline
`default_nettype none

`include "softreg_consts.svh"

module sr_pipe import softreg_pkg::*; #(
	parameter type payload_t = sr_data_t,
	parameter int  STAGES    = `RESP_PIPE_STAGES
) (
	input  logic     global_clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	logic [STAGES-1:0] valid_q;
	payload_t          payload_q [STAGES];

	// Valid bits shift with reset
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// Payload follows its valid bit stage by stage
	always_ff @(posedge global_clk) begin
		payload_q[0] <= in_payload;
		for (int i = 1; i < STAGES; i++) begin
			payload_q[i] <= payload_q[i-1];
		end
	end

	assign out_valid   = valid_q[STAGES-1];
	assign out_payload = payload_q[STAGES-1];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module shell_tb

# Keep running past an assertion error so the testbench prints its verdict
out=$(./obj_dir/Vshell_tb +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
exit 1

/* tb/shell_assertions.sv */
// AXI-Lite handshake assertions
`default_nettype none

`include "softreg_consts.svh"

module shell_assertions (
	input logic                    global_clk,
	input logic                    rst_n,
	input logic                    bvalid,
	input logic                    bready,
	input logic                    rvalid,
	input logic                    rready,
	input logic [`AXIL_DATA_W-1:0] rdata,
	input logic                    awready,
	input logic                    arready
);

	timeunit 1ns;
	timeprecision 1ps;

	// Count of failed assertions
	int error_count = 0;

	// Write response held until taken
	bvalid_held: assert property (@(posedge global_clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			error_count++;
			$error("bvalid dropped before bready");
		end

	// Read response and its data held until taken
	rvalid_held: assert property (@(posedge global_clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			error_count++;
			$error("rvalid or rdata changed before rready");
		end

	// One transaction at a time
	no_accept_pending: assert property (@(posedge global_clk) disable iff (!rst_n)
		(bvalid || rvalid) |-> !awready && !arready)
		else begin
			error_count++;
			$error("address accepted while a response was pending");
		end

endmodule

bind shell_top shell_assertions u_assertions (
	.global_clk(global_clk), .rst_n(rst_n),
	.bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
	.rdata(rdata), .awready(awready), .arready(arready)
);

`default_nettype wire

/* tb/shell_input.txt */
# Columns: operation (W or R), byte address in hex, data in hex
# Data is the write value on W lines and the expected read value on R lines
# Values after reset
R 00000000 00000000
R 00000004 00000000
R 00000008 00000000
R 0000000c 00000000
R 00000010 00000001
R 00000014 00000000
R 00000018 00000000
R 0000001c 00000000
R 00000020 00000002
R 00000024 00000000
R 00000028 00000000
R 0000002c 00000000
R 00000030 00000003
R 00000034 00000000
R 00000038 00000000
R 0000003c 00000000
# Scratch writes across all four applications
W 00000014 11110001
W 00000004 a0a0a0a0
W 00000024 22220002
W 00000034 33330003
W 00000028 2b2b2b2b
W 0000003c 3c3c3c3c
R 00000004 a0a0a0a0
R 00000014 11110001
R 00000024 22220002
R 00000034 33330003
R 00000018 00000000
R 00000028 2b2b2b2b
R 0000003c 3c3c3c3c
R 00000038 00000000
# Identity registers ignore writes
W 00000020 ffffffff
R 00000020 00000002
W 00000000 12345678
R 00000000 00000000
# High address bits alias
W abcd0018 5a5a5a5a
R 00000018 5a5a5a5a
R ffffff34 33330003
R 000000c4 a0a0a0a0

/* tb/shell_tb.sv */
// Host register shell testbench
`default_nettype none

`include "softreg_consts.svh"

module shell_tb import softreg_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES   = 8;
	localparam int CYCLES_PER_TXN = 40;

	logic                      global_clk;
	logic                      rst_n;
	logic                      awvalid;
	sr_addr_t                  awaddr;
	logic                      awready;
	logic                      wvalid;
	logic [`AXIL_DATA_W-1:0]   wdata;
	logic [`AXIL_DATA_W/8-1:0] wstrb;
	logic                      wready;
	logic                      bvalid;
	logic [1:0]                bresp;
	logic                      bready;
	logic                      arvalid;
	sr_addr_t                  araddr;
	logic                      arready;
	logic                      rvalid;
	logic [`AXIL_DATA_W-1:0]   rdata;
	logic [1:0]                rresp;
	logic                      rready;

	// Transactions from the data file
	byte                     txn_op [$];
	sr_addr_t                txn_addr [$];
	logic [`AXIL_DATA_W-1:0] txn_data [$];

	int seed;
	int pass_count;
	int fail_count;
	int err_count;
	int cycle_count;
	int cycle_limit;
	bit loaded = 1'b0;

	shell_top uut (
		.global_clk(global_clk), .rst_n(rst_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
	);

	initial begin
		global_clk = 1'b0;
		forever begin
			#5 global_clk = ~global_clk;
		end
	end

	// --------------------
	// Checks
	// --------------------
	task automatic check_read(input sr_data_t got, input sr_data_t expected, input sr_addr_t addr);
		if (got[`AXIL_DATA_W-1:0] !== expected[`AXIL_DATA_W-1:0]) begin
			$display("Mismatch at %0t ns: read of 0x%08h returned 0x%08h, expected 0x%08h",
				$time, addr, got[`AXIL_DATA_W-1:0], expected[`AXIL_DATA_W-1:0]);
			err_count++;
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input string name);
		if (got !== 2'b00) begin
			$display("Mismatch at %0t ns: %s was %0d, expected OKAY", $time, name, got);
			err_count++;
		end
	endtask

	// Ready held low while the pending response must stay put
	task automatic stall_response(input int delay);
		logic [`AXIL_DATA_W-1:0] first_rdata;
		first_rdata = rdata;
		repeat (delay) begin
			@(negedge global_clk);
			if (!(bvalid || rvalid)) begin
				$display("Response withdrawn at %0t ns before the host took it", $time);
				err_count++;
			end
			if (awready || arready) begin
				$display("New transaction accepted at %0t ns with a response pending", $time);
				err_count++;
			end
			if (rvalid && (rdata !== first_rdata)) begin
				$display("Read data changed at %0t ns while rvalid was held", $time);
				err_count++;
			end
		end
	endtask

	// --------------------
	// Host transactions
	// --------------------
	task automatic write_txn(input sr_addr_t addr, input logic [`AXIL_DATA_W-1:0] data);
		int delay;
		delay = $random(seed) & 3;
		@(posedge global_clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= '1;
		@(negedge global_clk);
		while (!(awready && wready)) @(negedge global_clk);
		@(posedge global_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge global_clk);
		while (!bvalid) @(negedge global_clk);
		stall_response(delay);
		@(posedge global_clk);
		bready <= 1'b1;
		@(negedge global_clk);
		if (!bvalid) begin
			$display("Write response missing at %0t ns when bready rose", $time);
			err_count++;
		end
		check_resp(bresp, "bresp");
		@(posedge global_clk);
		bready <= 1'b0;
	endtask

	task automatic read_txn(input sr_addr_t addr, input logic [`AXIL_DATA_W-1:0] expected);
		int delay;
		delay = $random(seed) & 3;
		@(posedge global_clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		@(negedge global_clk);
		while (!arready) @(negedge global_clk);
		@(posedge global_clk);
		arvalid <= 1'b0;
		@(negedge global_clk);
		while (!rvalid) @(negedge global_clk);
		stall_response(delay);
		@(posedge global_clk);
		rready <= 1'b1;
		@(negedge global_clk);
		if (!rvalid) begin
			$display("Read response missing at %0t ns when rready rose", $time);
			err_count++;
		end
		check_read(sr_data_t'(rdata), sr_data_t'(expected), addr);
		check_resp(rresp, "rresp");
		@(posedge global_clk);
		rready <= 1'b0;
	endtask

	task automatic run_txn(input int idx);
		int errs_before;
		errs_before = err_count + uut.u_assertions.error_count;
		if (txn_op[idx] == "W") begin
			write_txn(txn_addr[idx], txn_data[idx]);
		end else begin
			read_txn(txn_addr[idx], txn_data[idx]);
		end
		if (err_count + uut.u_assertions.error_count == errs_before) begin
			pass_count++;
			$display("Test %0d: %c 0x%08h passed", idx + 1, txn_op[idx], txn_addr[idx]);
		end else begin
			fail_count++;
			$display("Test %0d: %c 0x%08h failed", idx + 1, txn_op[idx], txn_addr[idx]);
		end
	endtask

	// Lines that are not W or R, such as comments, are skipped
	task automatic load_vectors();
		int                      fd;
		int                      rc;
		string                   line;
		byte                     op;
		sr_addr_t                addr;
		logic [`AXIL_DATA_W-1:0] data;
		fd = $fopen("tb/shell_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the data file tb/shell_input.txt");
			err_count++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				rc = $sscanf(line, "%c %h %h", op, addr, data);
				if ((rc == 3) && ((op == "W") || (op == "R"))) begin
					txn_op.push_back(op);
					txn_addr.push_back(addr);
					txn_data.push_back(data);
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		seed       = 32'hf08d;
		pass_count = 0;
		fail_count = 0;
		err_count  = 0;
		rst_n      = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		load_vectors();
		if (txn_op.size() == 0) begin
			$display("No transactions found in the data file");
			err_count++;
		end
		cycle_limit = CYCLES_PER_TXN * txn_op.size() + RESET_CYCLES;
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge global_clk);
		rst_n <= 1'b1;
		for (int i = 0; i < txn_op.size(); i++) begin
			run_txn(i);
		end
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if ((fail_count == 0) && (err_count == 0) && (uut.u_assertions.error_count == 0)) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Run limit scaled to the number of transactions
	initial begin
		cycle_count = 0;
		wait (loaded);
		while (cycle_count <= cycle_limit) begin
			@(posedge global_clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
